// ==== hdl/l1d_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_cache #(
    parameter int sets_log2 = 3
) (
    input  logic                clk,
    input  logic                nrst,
    input  logic                req_valid,
    input  l1d_pkg::cpu_req_t   req,
    input  logic                flush,
    output logic                busy,
    output logic                resp_valid,
    output l1d_pkg::word_t      resp_rdata,
    output logic                mem_req_valid,
    output l1d_pkg::mem_req_t   mem_req,
    output l1d_pkg::line_t      mem_wline,
    input  logic                mem_ready,
    input  l1d_pkg::line_t      mem_rline
);
    import l1d_pkg::*;

    // controller to data array
    logic [sets_log2-1:0] set_idx;
    logic                 way_sel;
    logic [offset_w-1:0]  word_sel;
    logic                 refill;
    logic                 update;
    word_t                wdata;

    l1d_tag_ctrl #(
        .sets_log2     (sets_log2)
    ) u_tag_ctrl (
        .clk           (clk),
        .nrst          (nrst),
        .req_valid     (req_valid),
        .req           (req),
        .flush         (flush),
        .mem_ready     (mem_ready),
        .busy          (busy),
        .resp_valid    (resp_valid),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .set_idx       (set_idx),
        .way_sel       (way_sel),
        .word_sel      (word_sel),
        .refill        (refill),
        .update        (update),
        .wdata         (wdata)
    );

    l1d_data_array #(
        .sets_log2   (sets_log2)
    ) u_data_array (
        .clk         (clk),
        .set_idx     (set_idx),
        .way_sel     (way_sel),
        .word_sel    (word_sel),
        .refill      (refill),
        .rline       (mem_rline),   // refill straight from L2
        .update      (update),
        .wdata       (wdata),
        .rdata       (resp_rdata),
        .victim_line (mem_wline)
    );

endmodule

`default_nettype wire

// ==== hdl/l1d_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_data_array #(
    parameter int sets_log2 = 3
) (
    input  logic                           clk,
    input  logic [sets_log2-1:0]           set_idx,
    input  logic                           way_sel,
    input  logic [l1d_pkg::offset_w-1:0]   word_sel,
    input  logic                           refill,
    input  l1d_pkg::line_t                 rline,
    input  logic                           update,
    input  l1d_pkg::word_t                 wdata,
    output l1d_pkg::word_t                 rdata,
    output l1d_pkg::line_t                 victim_line
);
    import l1d_pkg::*;

    localparam int num_sets = 1 << sets_log2;

    // two ways of line storage
    line_t lines [2][num_sets];

    always_ff @(posedge clk)
    begin
        if (refill)
            lines[way_sel][set_idx] <= rline;   // whole line from L2
        else if (update)
            lines[way_sel][set_idx][word_sel*word_w +: word_w] <= wdata;
    end

    // addressed entry, read without a clock
    assign victim_line = lines[way_sel][set_idx];
    assign rdata       = victim_line[word_sel*word_w +: word_w];

endmodule

`default_nettype wire

// ==== hdl/l1d_pkg.sv ====
`default_nettype none

package l1d_pkg;

    localparam int addr_w         = 32;
    localparam int word_w         = 32;
    localparam int words_per_line = 4;

    // word select within a line, byte bits below it are dropped
    localparam int offset_w   = $clog2(words_per_line);
    localparam int byte_off_w = 2;

    localparam int line_w = words_per_line * word_w;

    typedef logic [word_w-1:0] word_t;
    typedef logic [line_w-1:0] line_t;

    // processor request, one word
    typedef struct packed {
        logic              write;
        logic [addr_w-1:0] addr;
        word_t             wdata;
    } cpu_req_t;

    // L2 request, whole line
    typedef struct packed {
        logic              write;
        logic [addr_w-1:0] addr;   // in-line bits cleared
    } mem_req_t;

    typedef enum logic [1:0]
    {
        st_idle,
        st_compare,
        st_write_back,
        st_allocate
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/l1d_tag_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_tag_ctrl #(
    parameter int sets_log2 = 3
) (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           req_valid,
    input  l1d_pkg::cpu_req_t              req,
    input  logic                           flush,
    input  logic                           mem_ready,
    output logic                           busy,
    output logic                           resp_valid,
    output logic                           mem_req_valid,
    output l1d_pkg::mem_req_t              mem_req,
    output logic [sets_log2-1:0]           set_idx,
    output logic                           way_sel,
    output logic [l1d_pkg::offset_w-1:0]   word_sel,
    output logic                           refill,
    output logic                           update,
    output l1d_pkg::word_t                 wdata
);
    import l1d_pkg::*;

    localparam int num_sets = 1 << sets_log2;
    localparam int tag_w    = addr_w - sets_log2 - offset_w - byte_off_w;
    localparam int set_lsb  = byte_off_w + offset_w;

    ctrl_state_t state;
    ctrl_state_t next_state;

    cpu_req_t req_q;

    logic [tag_w-1:0] tag_mem [2][num_sets];
    logic [1:0][num_sets-1:0] valid_q;
    logic [1:0][num_sets-1:0] dirty_q;
    logic [num_sets-1:0] lru_q;   // way to replace next
    logic way_q;

    logic [tag_w-1:0]     req_tag;
    logic [sets_log2-1:0] set_q;
    logic [1:0]           tag_hit;
    logic                 hit;
    logic                 hit_way;
    logic                 victim;
    logic                 victim_dirty;
    logic                 cmp_way;

    assign req_tag = req_q.addr[addr_w-1 -: tag_w];
    assign set_q   = req_q.addr[set_lsb +: sets_log2];

    // tag match on both ways
    assign tag_hit[0] = valid_q[0][set_q] && (tag_mem[0][set_q] == req_tag);
    assign tag_hit[1] = valid_q[1][set_q] && (tag_mem[1][set_q] == req_tag);
    assign hit        = |tag_hit;
    assign hit_way    = tag_hit[1];

    // invalid way 0, then invalid way 1, else LRU
    always_comb
    begin
        if (!valid_q[0][set_q])
            victim = 1'b0;
        else if (!valid_q[1][set_q])
            victim = 1'b1;
        else
            victim = lru_q[set_q];
    end

    assign victim_dirty = valid_q[victim][set_q] && dirty_q[victim][set_q];
    assign cmp_way      = hit ? hit_way : victim;

    always_comb
    begin
        next_state = state;
        unique case (state)
            st_idle:       if (req_valid) next_state = st_compare;
            st_compare:
            begin
                if (hit)
                    next_state = st_idle;
                else if (victim_dirty)
                    next_state = st_write_back;
                else
                    next_state = st_allocate;
            end
            st_write_back: if (mem_ready) next_state = st_allocate;
            st_allocate:   if (mem_ready) next_state = st_compare;
            default:       next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state         <= st_idle;
            resp_valid    <= 1'b0;
            mem_req_valid <= 1'b0;
            way_q         <= 1'b0;
            lru_q         <= '0;
        end
        else
        begin
            state         <= next_state;
            resp_valid    <= (state == st_compare) && hit;
            // one strobe on entry to write-back or allocate
            mem_req_valid <= ((state == st_compare) && !hit) ||
                             ((state == st_write_back) && mem_ready);
            if (state == st_compare)
            begin
                way_q <= cmp_way;
                if (hit)
                    lru_q[set_q] <= ~hit_way;
            end
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if ((state == st_idle) && flush)
        begin
            valid_q <= '0;   // dirty data dropped
            dirty_q <= '0;
        end
        else if (refill)
        begin
            valid_q[way_q][set_q] <= 1'b1;
            dirty_q[way_q][set_q] <= 1'b0;
        end
        else if (update)
            dirty_q[hit_way][set_q] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if ((state == st_idle) && req_valid)
            req_q <= req;
        if (refill)
            tag_mem[way_q][set_q] <= req_tag;
    end

    assign busy   = (state != st_idle);
    assign refill = (state == st_allocate) && mem_ready;
    assign update = (state == st_compare) && hit && req_q.write;

    // write-back uses the victim's stored tag
    assign mem_req.write = (state == st_write_back);
    assign mem_req.addr  = {(state == st_write_back) ? tag_mem[way_q][set_q] : req_tag,
                            set_q, {set_lsb{1'b0}}};

    assign set_idx  = set_q;
    assign way_sel  = (state == st_compare) ? cmp_way : way_q;
    assign word_sel = req_q.addr[byte_off_w +: offset_w];
    assign wdata    = req_q.wdata;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the L1 data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_l1d_cache -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^Done: no errors$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== verif/l1d_cache_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_cache_assertions (
    input logic clk,
    input logic nrst,
    input logic req_valid,
    input logic busy,
    input logic resp_valid,
    input logic mem_req_valid
);
    int unsigned fail_count = 0;

    // strobes last one cycle
    a_resp_pulse: assert property (@(posedge clk) disable iff (!nrst)
        resp_valid |=> !resp_valid)
    else
    begin
        fail_count++;
        $error("resp_valid held longer than one cycle");
    end

    a_mem_req_pulse: assert property (@(posedge clk) disable iff (!nrst)
        mem_req_valid |=> !mem_req_valid)
    else
    begin
        fail_count++;
        $error("mem_req_valid held longer than one cycle");
    end

    a_resp_not_busy: assert property (@(posedge clk) disable iff (!nrst)
        resp_valid |-> !busy)
    else
    begin
        fail_count++;
        $error("busy high together with resp_valid");
    end

    a_req_not_busy: assert property (@(posedge clk) disable iff (!nrst)
        req_valid |-> !busy)
    else
    begin
        fail_count++;
        $error("request issued while the cache was busy");
    end

    // busy is low exactly in st_idle
    a_mem_req_not_idle: assert property (@(posedge clk) disable iff (!nrst)
        mem_req_valid |-> busy)
    else
    begin
        fail_count++;
        $error("L2 request raised while the controller was idle");
    end

endmodule

bind l1d_cache l1d_cache_assertions u_assertions (
    .clk           (clk),
    .nrst          (nrst),
    .req_valid     (req_valid),
    .busy          (busy),
    .resp_valid    (resp_valid),
    .mem_req_valid (mem_req_valid)
);

`default_nettype wire

// ==== verif/tb_l1d_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l1d_cache;
    import l1d_pkg::*;

    localparam int sets_log2 = 3;
    localparam int num_sets  = 1 << sets_log2;
    localparam int tag_w     = addr_w - sets_log2 - offset_w - byte_off_w;
    localparam int num_reqs  = 400;
    localparam int wait_max  = 200;

    logic     clk = 1'b0;
    logic     nrst, req_valid, flush, mem_ready;
    cpu_req_t req;
    line_t    mem_rline, mem_wline;
    logic     busy, resp_valid, mem_req_valid;
    word_t    resp_rdata;
    mem_req_t mem_req;

    logic [31:0] lfsr = 32'h521042bc;
    int          mismatches = 0;
    int          failures = 0;
    line_t       l2_mem [logic [addr_w-1:0]];   // written-back lines only

    // reference model state
    logic [tag_w-1:0] m_tag [2][num_sets];
    logic             m_valid [2][num_sets];
    logic             m_dirty [2][num_sets];
    line_t            m_data [2][num_sets];
    logic             m_lru [num_sets];

    l1d_cache #(.sets_log2(sets_log2)) u_l1d_cache (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
    endtask

    // untouched L2 contents, every word tied to its full address
    function automatic line_t fill_pattern(logic [addr_w-1:0] a);
        line_t l;
        for (int w = 0; w < words_per_line; w++)
            l[w*word_w +: word_w] = ~(a + 32'(w * 4)) ^ {a[15:0], a[31:16]};
        return l;
    endfunction

    function automatic line_t l2_read(logic [addr_w-1:0] a);
        return l2_mem.exists(a) ? l2_mem[a] : fill_pattern(a);
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        if (exp !== act)
        begin
            mismatches++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mem_req(string name, mem_req_t exp, mem_req_t act);
        if (exp !== act)
        begin
            mismatches++;
            $display("MISMATCH %s: expected write=%0b addr=%h, actual write=%0b addr=%h",
                     name, exp.write, exp.addr, act.write, act.addr);
        end
    endtask

    task automatic check_line(string name, line_t exp, line_t act);
        if (exp !== act)
        begin
            mismatches++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic await_l2_request(string name, output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (!ok && n < wait_max)
        begin
            @(negedge clk);
            n++;
            ok = mem_req_valid;
        end
        if (!ok)
        begin
            failures++;
            $display("%s: no L2 request arrived within %0d cycles", name, wait_max);
        end
    endtask

    // check one L2 strobe, then answer it after 1 to 4 cycles
    task automatic serve_l2(string name, mem_req_t exp, line_t exp_line, output bit ok);
        logic [31:0]       d;
        logic [addr_w-1:0] a;
        logic              wr;
        await_l2_request(name, ok);
        if (!ok)
            return;
        check_mem_req(name, exp, mem_req);
        a  = mem_req.addr;
        wr = mem_req.write;
        if (wr)
        begin
            check_line(name, exp_line, mem_wline);
            l2_mem[a] = mem_wline;
        end
        take_bits(2, d);
        repeat (d + 1) @(posedge clk);
        mem_ready <= 1'b1;
        mem_rline <= wr ? '0 : l2_read(a);
        @(posedge clk);
        mem_ready <= 1'b0;
    endtask

    // response is due on the second cycle after the start edge
    task automatic collect_response(string name, output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (!ok && n < wait_max)
        begin
            @(negedge clk);
            n++;
            ok = resp_valid;
            if (!ok && !busy)
            begin
                mismatches++;
                $display("MISMATCH %s busy: expected 1, actual 0", name);
            end
            if (mem_req_valid)
            begin
                failures++;
                $display("%s: L2 request while a response was expected", name);
            end
        end
        if (!ok)
        begin
            failures++;
            $display("%s: no response arrived within %0d cycles", name, wait_max);
        end
        else if (n != 2)
        begin
            mismatches++;
            $display("MISMATCH %s latency: expected 2, actual %0d", name, n);
        end
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (int k = 0; k < 2; k++)
            for (int s = 0; s < num_sets; s++)
            begin
                m_valid[k][s] = 1'b0;   // dirty lines are lost, no write-back
                m_dirty[k][s] = 1'b0;
            end
    endtask

    task automatic run_access(int i, output bit ok);
        logic [31:0]          r;
        logic [tag_w-1:0]     tag;
        logic [sets_log2-1:0] s;
        logic [offset_w-1:0]  w;
        logic                 wr, hit, way;
        word_t                wd;
        mem_req_t             exp;
        string                name;
        take_bits(1, r);
        wr = r[0];
        take_bits(3, r);
        tag = tag_w'(32'h00a5_c3e1 * (r % 6 + 1));   // six tags force conflicts
        take_bits(sets_log2, r);
        s = r[sets_log2-1:0];
        take_bits(offset_w, r);
        w = r[offset_w-1:0];
        take_bits(32, wd);
        hit = 1'b0;
        way = 1'b0;
        for (int k = 0; k < 2; k++)
            if (m_valid[k][s] && m_tag[k][s] == tag)
            begin
                hit = 1'b1;
                way = k[0];
            end
        name = $sformatf("req%0d_%s_%s", i, wr ? "write" : "read", hit ? "hit" : "miss");

        @(posedge clk);
        req_valid <= 1'b1;
        req       <= '{write: wr, addr: {tag, s, w, 2'b00}, wdata: wd};
        @(posedge clk);
        req_valid <= 1'b0;

        ok = 1'b1;
        if (!hit)
        begin
            way = !m_valid[0][s] ? 1'b0 : (!m_valid[1][s] ? 1'b1 : m_lru[s]);
            if (m_valid[way][s] && m_dirty[way][s])
            begin
                exp = '{write: 1'b1, addr: {m_tag[way][s], s, 4'b0000}};
                serve_l2({name, "_wb"}, exp, m_data[way][s], ok);
                if (!ok)
                    return;
            end
            exp = '{write: 1'b0, addr: {tag, s, 4'b0000}};
            serve_l2({name, "_fill"}, exp, '0, ok);
            if (!ok)
                return;
            m_tag[way][s]   = tag;
            m_valid[way][s] = 1'b1;
            m_dirty[way][s] = 1'b0;
            m_data[way][s]  = l2_read(exp.addr);
        end
        if (wr)
        begin
            m_data[way][s][w*word_w +: word_w] = wd;
            m_dirty[way][s] = 1'b1;
        end
        m_lru[s] = ~way;
        collect_response(name, ok);
        if (ok && !wr)
            check_word(name, m_data[way][s][w*word_w +: word_w], resp_rdata);
    endtask

    initial
    begin
        bit          ok;
        logic [31:0] r;
        int          assert_fails;
        nrst      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        flush     = 1'b0;
        mem_ready = 1'b0;
        mem_rline = '0;
        for (int s = 0; s < num_sets; s++)
        begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_dirty[0][s] = 1'b0;
            m_dirty[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        repeat (3) @(posedge clk);
        nrst <= 1'b1;

        ok = 1'b1;
        for (int i = 0; i < num_reqs && ok; i++)
        begin
            take_bits(5, r);
            if (r == 0)
                pulse_flush();   // about one request in 32
            run_access(i, ok);
        end

        assert_fails = u_l1d_cache.u_assertions.fail_count;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, assert_fails);
        if (mismatches + failures + assert_fails == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/l1d_pkg.sv
hdl/l1d_tag_ctrl.sv
hdl/l1d_data_array.sv
hdl/l1d_cache.sv
verif/l1d_cache_assertions.sv
verif/tb_l1d_cache.sv
